// ==== flist.f ====
hdl/clause_pkg.sv
hdl/clause_loader.sv
hdl/clause_cell.sv
hdl/clause_bin.sv
hdl/impl_merger.sv
hdl/clause_engine_top.sv
testbench/tb_clause_engine.sv

// ==== testbench/tb_clause_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clause_engine;

    logic                                    clk;
    logic                                    arst_n_i;
    logic                                    clause_wr_i;
    logic [clause_pkg::CLAUSE_ADDR_W-1:0]    clause_addr_i;
    logic [clause_pkg::LITS_W-1:0]           clause_lits_i;
    logic [clause_pkg::VALUE_W-1:0]          var_value_i;
    logic                                    apply_impl_i;
    logic                                    apply_bkt_i;
    logic [clause_pkg::VALUE_W-1:0]          var_value_o;
    logic                                    conflict_o;
    logic [clause_pkg::LEN_BUS_W-1:0]        clause_len_o;

    logic [clause_pkg::LITS_W-1:0]           model_lits [clause_pkg::NUM_CLAUSES];
    logic [31:0]                             lfsr;
    int                                      n_checks;
    int                                      n_errors;

    clause_engine_top u_dut (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .clause_wr_i   (clause_wr_i),
        .clause_addr_i (clause_addr_i),
        .clause_lits_i (clause_lits_i),
        .var_value_i   (var_value_i),
        .apply_impl_i  (apply_impl_i),
        .apply_bkt_i   (apply_bkt_i),
        .var_value_o   (var_value_o),
        .conflict_o    (conflict_o),
        .clause_len_o  (clause_len_o)
    );

    always #50 clk = ~clk;                                   // 100 ns period

    // ============================================================
    // Helpers
    // ============================================================
    task automatic step_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #10;                                             // Drive and sample after the edge
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);                          // One step per bit taken
        end
        return r;
    endfunction

    function automatic logic [clause_pkg::LITS_W-1:0] lit_mask(input int v, input bit neg);
        logic [clause_pkg::LITS_W-1:0] m;
        m = '0;
        m[v*clause_pkg::LIT_W +: clause_pkg::LIT_W] = neg ? 2'b10 : 2'b01;
        return m;
    endfunction

    function automatic logic [clause_pkg::VALUE_W-1:0] with_var(
        input logic [clause_pkg::VALUE_W-1:0] a,
        input int                             v,
        input logic [clause_pkg::VAR_STATE_W-1:0] st
    );
        logic [clause_pkg::VALUE_W-1:0] r;
        r = a;
        r[v*clause_pkg::VAR_STATE_W +: clause_pkg::VAR_STATE_W] = st;
        return r;
    endfunction

    // Variables that carry any literal bit
    function automatic int lit_count(input logic [clause_pkg::LITS_W-1:0] m);
        int n;
        n = 0;
        for (int v = 0; v < clause_pkg::NUM_VARS; v++) begin
            if (m[v*clause_pkg::LIT_W +: clause_pkg::LIT_W] != 2'b00) begin
                n++;
            end
        end
        return n;
    endfunction

    // About two literals per clause so units and conflicts both show up
    function automatic logic [clause_pkg::LITS_W-1:0] random_clause();
        logic [clause_pkg::LITS_W-1:0] m;
        logic [2:0]                    b;
        m = '0;
        for (int v = 0; v < clause_pkg::NUM_VARS; v++) begin
            b = take_bits(3);
            if (b[0] && b[1]) begin
                m[v*clause_pkg::LIT_W +: clause_pkg::LIT_W] = b[2] ? 2'b10 : 2'b01;
            end
        end
        return m;
    endfunction

    function automatic logic [clause_pkg::VALUE_W-1:0] random_assignment();
        logic [clause_pkg::VALUE_W-1:0] a;
        logic [2:0]                     b;
        a = '0;
        for (int v = 0; v < clause_pkg::NUM_VARS; v++) begin
            b = take_bits(3);
            a[v*clause_pkg::VAR_STATE_W +: clause_pkg::VAR_STATE_W] =
                {b[2], b[1:0] == 2'b10, b[0]};               // Bit 2 must be ignored on input
        end
        return a;
    endfunction

    // ============================================================
    // Reference model
    // ============================================================
    task automatic compute_expected(
        input  logic [clause_pkg::VALUE_W-1:0] a,
        output logic [clause_pkg::VALUE_W-1:0] ev,
        output logic                           ec
    );
        logic [clause_pkg::NUM_VARS-1:0] imp_t;
        logic [clause_pkg::NUM_VARS-1:0] imp_f;
        logic [1:0]                      f;
        logic                            is_t;
        logic                            is_f;
        logic                            sat;
        int                              n_free;
        int                              free_v;
        imp_t = '0;
        imp_f = '0;
        ev    = '0;
        ec    = 1'b0;
        for (int c = 0; c < clause_pkg::NUM_CLAUSES; c++) begin
            sat    = 1'b0;
            n_free = 0;
            free_v = 0;
            for (int v = 0; v < clause_pkg::NUM_VARS; v++) begin
                f    = model_lits[c][v*clause_pkg::LIT_W +: clause_pkg::LIT_W];
                is_t = a[v*clause_pkg::VAR_STATE_W + 1];
                is_f = a[v*clause_pkg::VAR_STATE_W];
                if (f == 2'b11 || (f == 2'b01 && is_t) || (f == 2'b10 && is_f)) begin
                    sat = 1'b1;
                end else if (f != 2'b00 && !is_t && !is_f) begin
                    n_free++;
                    free_v = v;
                end
            end
            if (model_lits[c] != '0 && !sat) begin
                if (n_free == 0) begin
                    ec = 1'b1;
                end else if (n_free == 1) begin
                    if (model_lits[c][free_v*clause_pkg::LIT_W]) begin
                        imp_t[free_v] = 1'b1;
                    end else begin
                        imp_f[free_v] = 1'b1;
                    end
                end
            end
        end
        for (int v = 0; v < clause_pkg::NUM_VARS; v++) begin
            if (imp_t[v] && imp_f[v]) begin
                ec = 1'b1;                                   // Opposing units leave the slice empty
            end else if (imp_t[v]) begin
                ev[v*clause_pkg::VAR_STATE_W +: clause_pkg::VAR_STATE_W] = clause_pkg::VS_IMPL_TRUE;
            end else if (imp_f[v]) begin
                ev[v*clause_pkg::VAR_STATE_W +: clause_pkg::VAR_STATE_W] = clause_pkg::VS_IMPL_FALSE;
            end
        end
    endtask

    // ============================================================
    // Checks and DUT access
    // ============================================================
    task automatic check_outputs(
        input logic [clause_pkg::VALUE_W-1:0] ev,
        input logic                           ec,
        input string                          tag
    );
        n_checks += 2;
        if (var_value_o !== ev) begin
            $display("ERR %0t: %s: var_value_o %h, expected %h", $time, tag, var_value_o, ev);
            n_errors++;
        end
        if (conflict_o !== ec) begin
            $display("ERR %0t: %s: conflict_o %b, expected %b", $time, tag, conflict_o, ec);
            n_errors++;
        end
    endtask

    task automatic check_slice(input int v, input logic [2:0] exp_st, input string tag);
        logic [2:0] got;
        got = var_value_o[v*clause_pkg::VAR_STATE_W +: clause_pkg::VAR_STATE_W];
        n_checks++;
        if (got !== exp_st) begin
            $display("ERR %0t: %s: variable %0d state %b, expected %b", $time, tag, v, got, exp_st);
            n_errors++;
        end
    endtask

    task automatic check_lengths(input string tag);
        logic [clause_pkg::WIDTH_C_LEN-1:0] got;
        logic [clause_pkg::WIDTH_C_LEN-1:0] exp_len;
        for (int c = 0; c < clause_pkg::NUM_CLAUSES; c++) begin
            got     = clause_len_o[c*clause_pkg::WIDTH_C_LEN +: clause_pkg::WIDTH_C_LEN];
            exp_len = lit_count(model_lits[c]);
            n_checks++;
            if (got !== exp_len) begin
                $display("ERR %0t: %s: length of slot %0d is %0d, expected %0d",
                         $time, tag, c, got, exp_len);
                n_errors++;
            end
        end
    endtask

    // Returns two edges after the strobe when the slot is stored
    task automatic write_clause(input int slot, input logic [clause_pkg::LITS_W-1:0] m);
        clause_wr_i      = 1'b1;
        clause_addr_i    = slot[clause_pkg::CLAUSE_ADDR_W-1:0];
        clause_lits_i    = m;
        model_lits[slot] = m;
        step_cycles(1);
        clause_wr_i      = 1'b0;
        step_cycles(1);
    endtask

    task automatic clear_bank();
        for (int c = 0; c < clause_pkg::NUM_CLAUSES; c++) begin
            write_clause(c, '0);
        end
    endtask

    task automatic apply_and_check(input logic [clause_pkg::VALUE_W-1:0] a, input string tag);
        logic [clause_pkg::VALUE_W-1:0] ev;
        logic                           ec;
        var_value_i  = a;
        apply_impl_i = 1'b1;
        step_cycles(2);
        compute_expected(a, ev, ec);
        check_outputs(ev, ec, tag);
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic reset_state_test();
        check_outputs('0, 1'b0, "reset");
        check_lengths("reset");
    endtask

    task automatic clause_write_test();
        write_clause(0, lit_mask(0, 0) | lit_mask(3, 1));
        check_lengths("write slot 0");
        write_clause(5, lit_mask(1, 0) | lit_mask(6, 0) | lit_mask(6, 1));
        check_lengths("write slot 5 with both polarities");
        write_clause(7, {clause_pkg::NUM_VARS{2'b01}});
        check_lengths("write full slot 7");
        for (int c = 2; c < 4; c++) begin
            write_clause(c, take_bits(clause_pkg::LITS_W));
            check_lengths("write random slot");
        end
        write_clause(0, '0);
        check_lengths("empty slot 0");
    endtask

    task automatic unit_impl_test();
        logic [clause_pkg::VALUE_W-1:0] a;
        clear_bank();
        write_clause(0, lit_mask(0, 0) | lit_mask(1, 1) | lit_mask(2, 0));
        write_clause(1, lit_mask(3, 1) | lit_mask(4, 0));
        write_clause(2, lit_mask(5, 0) | lit_mask(6, 0));  // Satisfied by x5 below
        a = '0;
        a = with_var(a, 0, clause_pkg::VS_FALSE);
        a = with_var(a, 1, clause_pkg::VS_TRUE);
        a = with_var(a, 4, clause_pkg::VS_FALSE);
        a = with_var(a, 5, clause_pkg::VS_TRUE);
        apply_and_check(a, "unit implication");
        check_slice(2, clause_pkg::VS_IMPL_TRUE, "unit positive");
        check_slice(3, clause_pkg::VS_IMPL_FALSE, "unit negated");
        check_slice(6, clause_pkg::VS_FREE, "satisfied clause");
        a = with_var(a, 2, clause_pkg::VS_TRUE);
        apply_and_check(a, "unit resolved");
    endtask

    task automatic conflict_test();
        logic [clause_pkg::VALUE_W-1:0] a;
        clear_bank();
        write_clause(0, lit_mask(0, 0) | lit_mask(1, 0));
        a = with_var('0, 0, clause_pkg::VS_FALSE);
        a = with_var(a, 1, clause_pkg::VS_FALSE);
        apply_and_check(a, "all literals false");
        if (conflict_o !== 1'b1) begin
            $display("ERR %0t: clause conflict not raised", $time);
            n_errors++;
        end
        clear_bank();
        write_clause(0, lit_mask(2, 0) | lit_mask(3, 0));
        write_clause(1, lit_mask(2, 1) | lit_mask(4, 0));
        a = with_var('0, 3, clause_pkg::VS_FALSE);
        a = with_var(a, 4, clause_pkg::VS_FALSE);
        apply_and_check(a, "opposing implications");
        if (conflict_o !== 1'b1) begin
            $display("ERR %0t: opposing implications raised no conflict", $time);
            n_errors++;
        end
        check_slice(2, clause_pkg::VS_FREE, "opposing implications");
    endtask

    task automatic hold_backtrack_test();
        logic [clause_pkg::VALUE_W-1:0] a;
        logic [clause_pkg::VALUE_W-1:0] ev;
        logic                           ec;
        clear_bank();
        write_clause(0, lit_mask(0, 0) | lit_mask(1, 0));
        write_clause(1, lit_mask(2, 1) | lit_mask(3, 0));
        a = with_var('0, 0, clause_pkg::VS_FALSE);
        a = with_var(a, 1, clause_pkg::VS_FALSE);
        a = with_var(a, 3, clause_pkg::VS_FALSE);
        apply_and_check(a, "hold setup");
        compute_expected(a, ev, ec);
        apply_impl_i = 1'b0;
        var_value_i  = '0;                                   // Would clear everything if applied
        step_cycles(2);
        check_outputs(ev, ec, "apply low holds");
        apply_bkt_i  = 1'b1;
        apply_impl_i = 1'b1;
        var_value_i  = a;
        step_cycles(1);
        apply_bkt_i  = 1'b0;
        apply_impl_i = 1'b0;
        step_cycles(1);
        check_outputs('0, 1'b0, "backtrack");
        step_cycles(2);
        check_outputs('0, 1'b0, "after backtrack");
    endtask

    task automatic random_regression_test();
        logic [clause_pkg::VALUE_W-1:0] a;
        logic [clause_pkg::VALUE_W-1:0] ev;
        logic                           ec;
        logic [clause_pkg::VALUE_W-1:0] exp_val_q [$];
        logic                           exp_conf_q [$];
        int                             n_vec;
        n_vec = 200;
        for (int c = 0; c < clause_pkg::NUM_CLAUSES; c++) begin
            write_clause(c, random_clause());
        end
        check_lengths("random bank");
        apply_impl_i = 1'b1;
        for (int i = 0; i < n_vec + 2; i++) begin
            if (i >= 2) begin
                ev = exp_val_q.pop_front();
                ec = exp_conf_q.pop_front();
                check_outputs(ev, ec, "random");
            end
            if (i < n_vec) begin
                a           = random_assignment();
                var_value_i = a;
                compute_expected(a, ev, ec);
                exp_val_q.push_back(ev);
                exp_conf_q.push_back(ec);
            end
            step_cycles(1);
        end
        apply_impl_i = 1'b0;
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        clause_wr_i   = 1'b0;
        clause_addr_i = '0;
        clause_lits_i = '0;
        var_value_i   = '0;
        apply_impl_i  = 1'b0;
        apply_bkt_i   = 1'b0;
        lfsr          = 32'h4ba3303a;
        n_checks      = 0;
        n_errors      = 0;
        for (int c = 0; c < clause_pkg::NUM_CLAUSES; c++) begin
            model_lits[c] = '0;
        end
        step_cycles(16);
        arst_n_i = 1'b1;
        step_cycles(1);

        reset_state_test();
        clause_write_test();
        unit_impl_test();
        conflict_test();
        hold_backtrack_test();
        random_regression_test();

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/clause_engine_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module clause_engine_top (
    input  wire                                       clk,
    input  wire                                       arst_n_i,

    // Clause loading
    input  wire                                       clause_wr_i,
    input  wire [clause_pkg::CLAUSE_ADDR_W-1:0]       clause_addr_i,
    input  wire [clause_pkg::LITS_W-1:0]              clause_lits_i,

    // Variable base side
    input  wire [clause_pkg::VALUE_W-1:0]             var_value_i,
    input  wire                                       apply_impl_i,
    input  wire                                       apply_bkt_i,
    output wire [clause_pkg::VALUE_W-1:0]             var_value_o,
    output wire                                       conflict_o,

    // Lengths for the replacement policy
    output wire [clause_pkg::LEN_BUS_W-1:0]           clause_len_o
);

    wire [clause_pkg::NUM_CLAUSES-1:0]  wr;
    wire [clause_pkg::LITS_W-1:0]       lits;
    wire [clause_pkg::WIDTH_C_LEN-1:0]  len;
    wire [clause_pkg::IMPL_BUS_W-1:0]   impl;
    wire [clause_pkg::NUM_CLAUSES-1:0]  cell_conflict;

    // ============================================================
    // Loader, bin and merger
    // ============================================================
    clause_loader u_loader (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .clause_wr_i   (clause_wr_i),
        .clause_addr_i (clause_addr_i),
        .clause_lits_i (clause_lits_i),
        .wr_o          (wr),
        .lits_o        (lits),
        .len_o         (len)
    );

    clause_bin u_bin (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .wr_i          (wr),
        .lits_i        (lits),
        .len_i         (len),
        .var_value_i   (var_value_i),
        .apply_impl_i  (apply_impl_i),
        .apply_bkt_i   (apply_bkt_i),
        .impl_o        (impl),
        .conflict_o    (cell_conflict),
        .clause_len_o  (clause_len_o)
    );

    impl_merger u_merger (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .impl_i        (impl),
        .conflict_i    (cell_conflict),
        .var_value_o   (var_value_o),
        .conflict_o    (conflict_o)
    );

endmodule

`default_nettype wire

// ==== hdl/impl_merger.sv ====
`timescale 1ns/10ps
`default_nettype none

module impl_merger (
    input  wire                                       clk,
    input  wire                                       arst_n_i,

    input  wire [clause_pkg::IMPL_BUS_W-1:0]          impl_i,
    input  wire [clause_pkg::NUM_CLAUSES-1:0]         conflict_i,

    output logic [clause_pkg::VALUE_W-1:0]            var_value_o,
    output logic                                      conflict_o
);

    logic [clause_pkg::VALUE_W-1:0]   impl_or;
    logic [clause_pkg::NUM_VARS-1:0]  opposing;
    logic [clause_pkg::VALUE_W-1:0]   value_next;
    logic                             conflict_next;

    // ============================================================
    // OR of all cell implications
    // ============================================================
    always_comb begin
        impl_or = '0;
        for (int c = 0; c < clause_pkg::NUM_CLAUSES; c++) begin
            impl_or = impl_or | impl_i[c*clause_pkg::VALUE_W +: clause_pkg::VALUE_W];
        end
    end

    // ============================================================
    // Opposing implications
    // ============================================================
    // Implied true and implied false OR together into both value bits
    for (genvar v = 0; v < clause_pkg::NUM_VARS; v++) begin : g_var
        localparam int SB = v * clause_pkg::VAR_STATE_W;

        assign opposing[v] =
            |(impl_or[SB +: clause_pkg::VAR_STATE_W] & clause_pkg::VS_TRUE) &&
            |(impl_or[SB +: clause_pkg::VAR_STATE_W] & clause_pkg::VS_FALSE);

        assign value_next[SB +: clause_pkg::VAR_STATE_W] =
            opposing[v] ? clause_pkg::VS_FREE : impl_or[SB +: clause_pkg::VAR_STATE_W];
    end

    assign conflict_next = (|conflict_i) || (|opposing);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            var_value_o <= '0;
            conflict_o  <= 1'b0;
        end else begin
            var_value_o <= value_next;                       // Follows the cells one cycle later
            conflict_o  <= conflict_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/clause_bin.sv ====
`timescale 1ns/10ps
`default_nettype none

module clause_bin (
    input  wire                                       clk,
    input  wire                                       arst_n_i,

    input  wire [clause_pkg::NUM_CLAUSES-1:0]         wr_i,
    input  wire [clause_pkg::LITS_W-1:0]              lits_i,
    input  wire [clause_pkg::WIDTH_C_LEN-1:0]         len_i,

    input  wire [clause_pkg::VALUE_W-1:0]             var_value_i,
    input  wire                                       apply_impl_i,
    input  wire                                       apply_bkt_i,

    output logic [clause_pkg::IMPL_BUS_W-1:0]         impl_o,
    output logic [clause_pkg::NUM_CLAUSES-1:0]        conflict_o,
    output logic [clause_pkg::LEN_BUS_W-1:0]          clause_len_o
);

    // ============================================================
    // Clause cells
    // ============================================================
    // Cell c owns slice c of every per-clause bus
    for (genvar c = 0; c < clause_pkg::NUM_CLAUSES; c++) begin : g_cell
        clause_cell u_cell (
            .clk          (clk),
            .arst_n_i     (arst_n_i),

            .wr_i         (wr_i[c]),
            .lits_i       (lits_i),
            .len_i        (len_i),

            .var_value_i  (var_value_i),
            .apply_impl_i (apply_impl_i),
            .apply_bkt_i  (apply_bkt_i),

            .impl_o       (impl_o[c*clause_pkg::VALUE_W +: clause_pkg::VALUE_W]),
            .conflict_o   (conflict_o[c]),
            .clause_len_o (clause_len_o[c*clause_pkg::WIDTH_C_LEN +: clause_pkg::WIDTH_C_LEN])
        );
    end

endmodule

`default_nettype wire

// ==== hdl/clause_cell.sv ====
`timescale 1ns/10ps
`default_nettype none

module clause_cell (
    input  wire                                       clk,
    input  wire                                       arst_n_i,

    input  wire                                       wr_i,
    input  wire [clause_pkg::LITS_W-1:0]              lits_i,
    input  wire [clause_pkg::WIDTH_C_LEN-1:0]         len_i,

    input  wire [clause_pkg::VALUE_W-1:0]             var_value_i,
    input  wire                                       apply_impl_i,
    input  wire                                       apply_bkt_i,

    output logic [clause_pkg::VALUE_W-1:0]            impl_o,
    output logic                                      conflict_o,
    output logic [clause_pkg::WIDTH_C_LEN-1:0]        clause_len_o
);

    logic [clause_pkg::LITS_W-1:0]       lits_q;
    logic [clause_pkg::WIDTH_C_LEN-1:0]  len_q;

    logic [clause_pkg::NUM_VARS-1:0]     lit_pos;
    logic [clause_pkg::NUM_VARS-1:0]     lit_neg;
    logic [clause_pkg::NUM_VARS-1:0]     var_true;
    logic [clause_pkg::NUM_VARS-1:0]     var_false;
    logic [clause_pkg::NUM_VARS-1:0]     lit_true;
    logic [clause_pkg::NUM_VARS-1:0]     lit_free;

    logic                                valid;
    logic                                satisfied;
    logic                                unit;
    logic                                conflict_next;
    logic [clause_pkg::VALUE_W-1:0]      impl_next;

    // ============================================================
    // Clause storage
    // ============================================================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lits_q <= '0;
            len_q  <= '0;                                    // Empty clause never evaluates
        end else if (wr_i) begin
            lits_q <= lits_i;
            len_q  <= len_i;
        end
    end

    assign clause_len_o = len_q;

    // ============================================================
    // Literal evaluation
    // ============================================================
    for (genvar v = 0; v < clause_pkg::NUM_VARS; v++) begin : g_var
        localparam int LB = v * clause_pkg::LIT_W;
        localparam int SB = v * clause_pkg::VAR_STATE_W;

        assign lit_pos[v]   = lits_q[LB + clause_pkg::LIT_POS];
        assign lit_neg[v]   = lits_q[LB + clause_pkg::LIT_NEG];
        assign var_true[v]  = |(var_value_i[SB +: clause_pkg::VAR_STATE_W] & clause_pkg::VS_TRUE);
        assign var_false[v] = |(var_value_i[SB +: clause_pkg::VAR_STATE_W] & clause_pkg::VS_FALSE);

        // Both polarities present makes the clause a tautology
        assign lit_true[v]  = (lit_pos[v] & lit_neg[v]) |
                              (lit_pos[v] & var_true[v]) |
                              (lit_neg[v] & var_false[v]);
        assign lit_free[v]  = (lit_pos[v] ^ lit_neg[v]) & ~var_true[v] & ~var_false[v];

        assign impl_next[SB +: clause_pkg::VAR_STATE_W] =
            (unit && lit_free[v]) ? (lit_pos[v] ? clause_pkg::VS_IMPL_TRUE
                                                : clause_pkg::VS_IMPL_FALSE)
                                  : clause_pkg::VS_FREE;
    end

    assign valid     = (len_q != '0);
    assign satisfied = |lit_true;

    // Exactly one free literal is left when the free vector is one-hot
    assign unit = valid && !satisfied && (lit_free != '0) &&
                  ((lit_free & (lit_free - 1'b1)) == '0);

    assign conflict_next = valid && !satisfied && (lit_free == '0);

    // ============================================================
    // Result register
    // ============================================================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            impl_o     <= '0;
            conflict_o <= 1'b0;
        end else if (apply_bkt_i) begin
            impl_o     <= '0;                                // Backtrack wins over apply
            conflict_o <= 1'b0;
        end else if (apply_impl_i) begin
            impl_o     <= impl_next;
            conflict_o <= conflict_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/clause_loader.sv ====
`timescale 1ns/10ps
`default_nettype none

module clause_loader (
    input  wire                                       clk,
    input  wire                                       arst_n_i,

    input  wire                                       clause_wr_i,
    input  wire [clause_pkg::CLAUSE_ADDR_W-1:0]       clause_addr_i,
    input  wire [clause_pkg::LITS_W-1:0]              clause_lits_i,

    output logic [clause_pkg::NUM_CLAUSES-1:0]        wr_o,
    output logic [clause_pkg::LITS_W-1:0]             lits_o,
    output logic [clause_pkg::WIDTH_C_LEN-1:0]        len_o
);

    logic [clause_pkg::NUM_CLAUSES-1:0]  wr_dec;
    logic [clause_pkg::WIDTH_C_LEN-1:0]  lit_cnt;

    // ============================================================
    // Slot decode
    // ============================================================
    always_comb begin
        wr_dec                = '0;
        wr_dec[clause_addr_i] = clause_wr_i;                 // One bit at most per strobe
    end

    // ============================================================
    // Literal count
    // ============================================================
    // A variable counts once, even when both of its literal bits are set
    always_comb begin
        lit_cnt = '0;
        for (int v = 0; v < clause_pkg::NUM_VARS; v++) begin
            if (|clause_lits_i[v*clause_pkg::LIT_W +: clause_pkg::LIT_W]) begin
                lit_cnt = lit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_o <= '0;
        end else begin
            wr_o <= wr_dec;                                  // Strobe lasts a single cycle
        end
    end

    // The clause payload is only meaningful while a bit of wr_o is high
    always_ff @(posedge clk) begin
        if (clause_wr_i) begin
            lits_o <= clause_lits_i;
            len_o  <= lit_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/clause_pkg.sv ====
`default_nettype none

package clause_pkg;

    // ============================================================
    // Bank geometry
    // ============================================================
    localparam int NUM_CLAUSES   = 8;                        // Clause slots in the bank
    localparam int NUM_VARS      = 8;                        // Variables in the bin
    localparam int CLAUSE_ADDR_W = 3;                        // Selects one slot
    localparam int WIDTH_C_LEN   = 4;                        // Holds a length up to NUM_VARS

    // ============================================================
    // Per-variable fields
    // ============================================================
    localparam int VAR_STATE_W   = 3;
    localparam int LIT_W         = 2;
    localparam int LIT_POS       = 0;                        // Positive literal bit in a field
    localparam int LIT_NEG       = 1;                        // Negated literal bit in a field

    // Packed buses hold variable or clause 0 in the lowest slice
    localparam int LITS_W        = NUM_VARS * LIT_W;
    localparam int VALUE_W       = NUM_VARS * VAR_STATE_W;
    localparam int IMPL_BUS_W    = NUM_CLAUSES * VALUE_W;
    localparam int LEN_BUS_W     = NUM_CLAUSES * WIDTH_C_LEN;

    // ============================================================
    // Variable-state encoding
    // ============================================================
    // Bit 2 only carries meaning on the outputs towards the base
    localparam logic [VAR_STATE_W-1:0] VS_FREE       = 3'b000; // Unassigned or no implication
    localparam logic [VAR_STATE_W-1:0] VS_FALSE      = 3'b001;
    localparam logic [VAR_STATE_W-1:0] VS_TRUE       = 3'b010;
    localparam logic [VAR_STATE_W-1:0] VS_IMPL_FALSE = 3'b101;
    localparam logic [VAR_STATE_W-1:0] VS_IMPL_TRUE  = 3'b110;

endpackage

`default_nettype wire
